//--- Makefile
TOP   := tb_conv_tile_top
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee sim.log
	@grep -q "All tests passed!" sim.log || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) sim.log

//--- design/accel_params.svh
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// Systolic array side length
`define SA_N 4

// Number of convolution layers in the layer table
`define NUM_LAYERS 3

// Tile job buffer entries
`define JOB_FIFO_DEPTH 4

// Output heights, widths and tile positions
`define DIM_W 8

// Channel counts and indices
`define CH_W 8

// Kernel height and width
`define KER_W 4

`endif

//--- design/conv_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tile_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  output logic                       busy,
  output logic                       done,
  output logic                       result_req,
  output tile_job_pkg::tile_result_t result,
  input  logic                       result_ack
);

  import tile_job_pkg::*;

  logic      push_req;
  logic      push_ack;
  tile_job_t push_job;
  logic      pop_req;
  logic      pop_ack;
  tile_job_t pop_job;
  logic      run_done;

  // Done is the engine's pulse after the last result is released
  assign done = run_done;

  layer_controller i_layer_controller (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .run_done (run_done),
    .busy     (busy),
    .push_req (push_req),
    .job      (push_job),
    .push_ack (push_ack)
  );

  job_fifo i_job_fifo (
    .clk       (clk),
    .reset     (reset),
    .push_req  (push_req),
    .push_data (push_job),
    .push_ack  (push_ack),
    .pop_req   (pop_req),
    .pop_data  (pop_job),
    .pop_ack   (pop_ack)
  );

  tile_engine i_tile_engine (
    .clk        (clk),
    .reset      (reset),
    .job_req    (pop_req),
    .job        (pop_job),
    .job_ack    (pop_ack),
    .result_req (result_req),
    .result     (result),
    .result_ack (result_ack),
    .run_done   (run_done)
  );

endmodule

`default_nettype wire

//--- design/job_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module job_fifo (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push_req,
  input  tile_job_pkg::tile_job_t push_data,
  output logic                    push_ack,
  output logic                    pop_req,
  output tile_job_pkg::tile_job_t pop_data,
  input  logic                    pop_ack
);

  import tile_job_pkg::*;

  localparam int DEPTH = `JOB_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  tile_job_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  // Set from pop until the consumer drops its ack
  logic             rd_wait;
  logic             do_push;
  logic             do_pop;

  // push_ack doubles as the write side phase bit
  assign do_push  = push_req && !push_ack && (count != CNT_W'(DEPTH));
  assign do_pop   = pop_req && pop_ack && !rd_wait;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      push_ack <= 1'b0;
      pop_req  <= 1'b0;
      rd_wait  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr   <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        push_ack <= 1'b1;
      end else if (push_ack && !push_req) begin
        push_ack <= 1'b0;
      end

      if (do_pop) begin
        rd_ptr  <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        pop_req <= 1'b0;
        rd_wait <= 1'b1;
      end else if (rd_wait) begin
        if (!pop_ack) rd_wait <= 1'b0;
      end else if (!pop_req && (count != '0)) begin
        pop_req <= 1'b1;
      end

      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- design/layer_cfg_pkg.sv
`default_nettype none

`include "accel_params.svh"

package layer_cfg_pkg;

  typedef logic [`DIM_W-1:0] dim_t;
  typedef logic [`CH_W-1:0]  chan_t;
  typedef logic [`KER_W-1:0] ker_t;
  typedef logic [1:0]        layer_idx_t;

  // One convolution layer as seen by the tile sequencer
  typedef struct packed {
    dim_t  out_h;
    dim_t  out_w;
    chan_t out_c;
    ker_t  kernel_h;
    ker_t  kernel_w;
  } layer_cfg_t;

  // Fixed network description, walked in order by the controller
  localparam layer_cfg_t LAYER_TABLE [`NUM_LAYERS] = '{
    '{out_h:    dim_t'(6),
      out_w:    dim_t'(6),
      out_c:    chan_t'(2),
      kernel_h: ker_t'(3),
      kernel_w: ker_t'(3)},
    '{out_h:    dim_t'(4),
      out_w:    dim_t'(4),
      out_c:    chan_t'(3),
      kernel_h: ker_t'(2),
      kernel_w: ker_t'(2)},
    // Final layer is a 1x1 classifier style layer
    '{out_h:    dim_t'(1),
      out_w:    dim_t'(1),
      out_c:    chan_t'(4),
      kernel_h: ker_t'(1),
      kernel_w: ker_t'(1)}
  };

endpackage

`default_nettype wire

//--- design/layer_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module layer_controller (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    run_done,
  output logic                    busy,
  output logic                    push_req,
  output tile_job_pkg::tile_job_t job,
  input  logic                    push_ack
);

  import layer_cfg_pkg::*;
  import tile_job_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ISSUE,
    WAIT_ACK,
    WAIT_RELEASE,
    DRAIN
  } state_t;

  state_t     state;

  // Position in the layer / channel / tile walk
  layer_idx_t layer_cnt;
  chan_t      chan_cnt;
  dim_t       tile_row;
  dim_t       tile_col;

  layer_cfg_t cfg;
  dim_t       tiles_h;
  dim_t       tiles_w;
  dim_t       row_org;
  dim_t       col_org;
  dim_t       rem_h;
  dim_t       rem_w;
  logic       last_col;
  logic       last_row;
  logic       last_chan;
  logic       last_layer;
  logic       last_job;
  tile_job_t  next_job;

  always_comb begin
    cfg = LAYER_TABLE[layer_cnt];

    // Tile grid is ceil(out / SA_N) in each direction
    tiles_h = dim_t'((cfg.out_h + `SA_N - 1) / `SA_N);
    tiles_w = dim_t'((cfg.out_w + `SA_N - 1) / `SA_N);

    row_org = dim_t'(tile_row * `SA_N);
    col_org = dim_t'(tile_col * `SA_N);
    rem_h   = cfg.out_h - row_org;
    rem_w   = cfg.out_w - col_org;

    last_col   = (tile_col == tiles_w - 1'b1);
    last_row   = (tile_row == tiles_h - 1'b1);
    last_chan  = (chan_cnt == cfg.out_c - 1'b1);
    last_layer = (layer_cnt == layer_idx_t'(`NUM_LAYERS - 1));
    last_job   = last_col && last_row && last_chan && last_layer;

    next_job.layer    = layer_cnt;
    next_job.channel  = chan_cnt;
    next_job.row      = row_org;
    next_job.col      = col_org;
    // Edge tiles shrink to whatever output is left
    next_job.tile_h   = (rem_h < dim_t'(`SA_N)) ? rem_h : dim_t'(`SA_N);
    next_job.tile_w   = (rem_w < dim_t'(`SA_N)) ? rem_w : dim_t'(`SA_N);
    next_job.kernel_h = cfg.kernel_h;
    next_job.kernel_w = cfg.kernel_w;
    next_job.first_in_channel = (tile_row == '0) && (tile_col == '0);
    next_job.bypass_pool      = last_layer;
    next_job.last_job         = last_job;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      busy      <= 1'b0;
      push_req  <= 1'b0;
      layer_cnt <= '0;
      chan_cnt  <= '0;
      tile_row  <= '0;
      tile_col  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            busy      <= 1'b1;
            layer_cnt <= '0;
            chan_cnt  <= '0;
            tile_row  <= '0;
            tile_col  <= '0;
            state     <= ISSUE;
          end
        end

        // Job fields are captured here, req follows next cycle
        ISSUE: begin
          push_req <= 1'b1;
          state    <= WAIT_ACK;
        end

        WAIT_ACK: begin
          if (push_ack) begin
            push_req <= 1'b0;
            state    <= WAIT_RELEASE;
          end
        end

        WAIT_RELEASE: begin
          if (!push_ack) begin
            if (last_job) begin
              state <= DRAIN;
            end else begin
              state <= ISSUE;
              // Column is the innermost loop, layer the outermost
              if (!last_col) begin
                tile_col <= tile_col + 1'b1;
              end else begin
                tile_col <= '0;
                if (!last_row) begin
                  tile_row <= tile_row + 1'b1;
                end else begin
                  tile_row <= '0;
                  if (!last_chan) begin
                    chan_cnt <= chan_cnt + 1'b1;
                  end else begin
                    chan_cnt  <= '0;
                    layer_cnt <= layer_cnt + 1'b1;
                  end
                end
              end
            end
          end
        end

        // Jobs still in flight, wait for the engine to finish the last one
        DRAIN: begin
          if (run_done) begin
            busy  <= 1'b0;
            state <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // Held stable for the whole push handshake
  always_ff @(posedge clk) begin
    if (state == ISSUE) begin
      job <= next_job;
    end
  end

endmodule

`default_nettype wire

//--- design/tile_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module tile_engine (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       job_req,
  input  tile_job_pkg::tile_job_t    job,
  output logic                       job_ack,
  output logic                       result_req,
  output tile_job_pkg::tile_result_t result,
  input  logic                       result_ack,
  output logic                       run_done
);

  import tile_job_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ACCEPT,
    BIAS,
    COMPUTE,
    OFFER,
    RELEASE
  } state_t;

  state_t                   state;
  tile_job_t                job_q;
  logic [`SA_N*`SA_N-1:0]   pe_mask;
  pe_count_t                active_pes;
  mac_t                     mac_count;
  logic [2*`KER_W-1:0]      taps;
  logic [2*`KER_W-1:0]      tap_cnt;

  // PE (r, c) is active when it lies inside the tile
  always_comb begin
    pe_mask    = '0;
    active_pes = '0;
    for (int r = 0; r < `SA_N; r++) begin
      for (int c = 0; c < `SA_N; c++) begin
        pe_mask[r*`SA_N + c] = (r < job_q.tile_h) && (c < job_q.tile_w);
      end
    end
    for (int i = 0; i < `SA_N*`SA_N; i++) begin
      active_pes = active_pes + pe_count_t'(pe_mask[i]);
    end
  end

  assign taps      = job_q.kernel_h * job_q.kernel_w;
  assign mac_count = mac_t'(active_pes) * mac_t'(job_q.kernel_h) * mac_t'(job_q.kernel_w);

  always_comb begin
    result.layer       = job_q.layer;
    result.channel     = job_q.channel;
    result.row         = job_q.row;
    result.col         = job_q.col;
    result.active_pes  = active_pes;
    result.mac_count   = mac_count;
    result.bypass_pool = job_q.bypass_pool;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= IDLE;
      job_ack    <= 1'b0;
      result_req <= 1'b0;
      run_done   <= 1'b0;
      tap_cnt    <= '0;
    end else begin
      run_done <= 1'b0;
      case (state)
        IDLE: begin
          if (job_req) begin
            job_ack <= 1'b1;
            state   <= ACCEPT;
          end
        end

        // Hold ack until the FIFO withdraws its request
        ACCEPT: begin
          if (!job_req) begin
            job_ack <= 1'b0;
            tap_cnt <= taps - 1'b1;
            state   <= job_q.first_in_channel ? BIAS : COMPUTE;
          end
        end

        // Single cycle bias load at the start of a channel
        BIAS: state <= COMPUTE;

        // One cycle per kernel tap
        COMPUTE: begin
          if (tap_cnt == '0) begin
            result_req <= 1'b1;
            state      <= OFFER;
          end else begin
            tap_cnt <= tap_cnt - 1'b1;
          end
        end

        OFFER: begin
          if (result_ack) begin
            result_req <= 1'b0;
            state      <= RELEASE;
          end
        end

        RELEASE: begin
          if (!result_ack) begin
            run_done <= job_q.last_job;
            state    <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && job_req) begin
      job_q <= job;
    end
  end

endmodule

`default_nettype wire

//--- design/tile_job_pkg.sv
`default_nettype none

`include "accel_params.svh"

package tile_job_pkg;

  // Number of active PEs, 0 up to the full array
  typedef logic [$clog2(`SA_N*`SA_N+1)-1:0] pe_count_t;

  // Multiply-accumulate total for one tile
  typedef logic [11:0] mac_t;

  // Work item from the layer controller to the tile engine
  typedef struct packed {
    layer_cfg_pkg::layer_idx_t layer;
    layer_cfg_pkg::chan_t      channel;
    layer_cfg_pkg::dim_t       row;
    layer_cfg_pkg::dim_t       col;
    layer_cfg_pkg::dim_t       tile_h;
    layer_cfg_pkg::dim_t       tile_w;
    layer_cfg_pkg::ker_t       kernel_h;
    layer_cfg_pkg::ker_t       kernel_w;
    logic                      first_in_channel;
    logic                      bypass_pool;
    logic                      last_job;
  } tile_job_t;

  // Tile summary handed out of the subsystem
  typedef struct packed {
    layer_cfg_pkg::layer_idx_t layer;
    layer_cfg_pkg::chan_t      channel;
    layer_cfg_pkg::dim_t       row;
    layer_cfg_pkg::dim_t       col;
    pe_count_t                 active_pes;
    mac_t                      mac_count;
    logic                      bypass_pool;
  } tile_result_t;

endpackage

`default_nettype wire

//--- flist.f
+incdir+design
design/layer_cfg_pkg.sv
design/tile_job_pkg.sv
design/layer_controller.sv
design/job_fifo.sv
design/tile_engine.sv
design/conv_tile_top.sv
test/tb_conv_tile_top.sv

//--- test/tb_conv_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_params.svh"

module tb_conv_tile_top;

  import layer_cfg_pkg::*;
  import tile_job_pkg::*;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 8;
  localparam int RUN_RESULTS      = 15;
  localparam int NUM_RUNS         = 2;
  localparam int JOB_CYCLES       = 40;
  localparam int RUN_TIMEOUT      = RUN_RESULTS * JOB_CYCLES + 200;
  localparam int WATCHDOG_CYCLES  = NUM_RUNS * RUN_RESULTS * JOB_CYCLES + 400;
  localparam int LONG_HOLD_IDX    = 2;
  localparam int LONG_HOLD_CYCLES = 60;
  localparam int POKE_IDX         = 5;

  // Network shape as out_h, out_w, out_c, kernel_h and kernel_w per layer
  localparam int OUT_H [`NUM_LAYERS] = '{6, 4, 1};
  localparam int OUT_W [`NUM_LAYERS] = '{6, 4, 1};
  localparam int OUT_C [`NUM_LAYERS] = '{2, 3, 4};
  localparam int KER_H [`NUM_LAYERS] = '{3, 2, 1};
  localparam int KER_W [`NUM_LAYERS] = '{3, 2, 1};

  logic         clk;
  logic         reset;
  logic         start;
  logic         busy;
  logic         done;
  logic         result_req;
  tile_result_t result;
  logic         result_ack;

  tile_result_t expected [RUN_RESULTS];
  tile_result_t first_run [RUN_RESULTS];
  string        test_name;
  int           check_count;
  int           fail_count;
  int           test_count;
  int           tests_failed;
  int           test_fail_base;
  int           result_idx;
  int           done_count;
  int           current_run;
  logic         fifo_full_seen;
  integer       seed = 98;

  conv_tile_top i_conv_tile_top (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .result_req (result_req),
    .result     (result),
    .result_ack (result_ack)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic record_failure(input string what);
    fail_count++;
    $display("%s: %s", test_name, what);
  endtask

  task automatic check_field(input string field, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    assert (act_val === exp_val) else begin
      fail_count++;
      $display("FAIL %s %s expected %0d actual %0d", test_name, field, exp_val, act_val);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1) else record_failure(what);
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_fail_base = fail_count;
  endtask

  task automatic end_test();
    int errs;
    errs = fail_count - test_fail_base;
    test_count++;
    if (errs == 0) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, errs);
    end
  endtask

  // Walk layers, channels, tile rows and tile columns in issue order
  task automatic build_expected_results();
    int n;
    int th;
    int tw;
    n = 0;
    for (int l = 0; l < `NUM_LAYERS; l++) begin
      for (int ch = 0; ch < OUT_C[l]; ch++) begin
        for (int r = 0; r < OUT_H[l]; r += `SA_N) begin
          for (int c = 0; c < OUT_W[l]; c += `SA_N) begin
            // Edge tiles only cover what is left of the output
            th = (OUT_H[l] - r < `SA_N) ? OUT_H[l] - r : `SA_N;
            tw = (OUT_W[l] - c < `SA_N) ? OUT_W[l] - c : `SA_N;
            expected[n].layer       = layer_idx_t'(l);
            expected[n].channel     = chan_t'(ch);
            expected[n].row         = dim_t'(r);
            expected[n].col         = dim_t'(c);
            expected[n].active_pes  = pe_count_t'(th * tw);
            expected[n].mac_count   = mac_t'(th * tw * KER_H[l] * KER_W[l]);
            expected[n].bypass_pool = (l == `NUM_LAYERS - 1);
            n++;
          end
        end
      end
    end
  endtask

  task automatic check_result(input tile_result_t got);
    tile_result_t exp;
    if (result_idx >= RUN_RESULTS) begin
      record_failure($sformatf("extra result after the %0d expected ones", RUN_RESULTS));
    end else begin
      exp = expected[result_idx];
      check_field($sformatf("result %0d layer", result_idx), exp.layer, got.layer);
      check_field($sformatf("result %0d channel", result_idx), exp.channel, got.channel);
      check_field($sformatf("result %0d row", result_idx), exp.row, got.row);
      check_field($sformatf("result %0d col", result_idx), exp.col, got.col);
      check_field($sformatf("result %0d active_pes", result_idx),
                  exp.active_pes, got.active_pes);
      check_field($sformatf("result %0d mac_count", result_idx),
                  exp.mac_count, got.mac_count);
      check_field($sformatf("result %0d bypass_pool", result_idx),
                  exp.bypass_pool, got.bypass_pool);
      if (current_run == 1) begin
        first_run[result_idx] = got;
      end else begin
        check_count++;
        assert (got === first_run[result_idx]) else begin
          fail_count++;
          $display("FAIL %s result %0d vs run 1 expected %h actual %h",
                   test_name, result_idx, first_run[result_idx], got);
        end
      end
    end
  endtask

  // Result receiver with random ack delay and one long hold per run
  initial begin : result_receiver
    tile_result_t got;
    int           hold_cycles;
    result_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && result_req && !result_ack) begin
        got = result;
        check_result(got);
        if (result_idx == LONG_HOLD_IDX) begin
          hold_cycles = LONG_HOLD_CYCLES;
        end else begin
          hold_cycles = ($random(seed) & 32'h7fff_ffff) % 6;
        end
        result_idx++;
        repeat (hold_cycles) @(posedge clk);
        result_ack <= 1'b1;
        do @(posedge clk); while (result_req);
        result_ack <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && done) begin
      done_count = done_count + 1;
      check_field("results taken before done", RUN_RESULTS, result_idx);
    end
    if (!reset && int'(i_conv_tile_top.i_job_fifo.count) == `JOB_FIFO_DEPTH) begin
      fifo_full_seen = 1'b1;
    end
  end

  result_held: assert property (@(posedge clk) disable iff (reset)
    (result_req && !result_ack) |=> (result_req && $stable(result)))
    else record_failure("result_req dropped or result changed before ack");

  req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
    $rose(result_req) |-> !result_ack)
    else record_failure("result_req rose while ack was still high");

  done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else record_failure("done stayed high for more than one cycle");

  done_in_run: assert property (@(posedge clk) disable iff (reset) done |-> busy)
    else record_failure("done pulsed while busy was low");

  idle_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
    else record_failure("busy still high after the done pulse");

  busy_until_done: assert property (@(posedge clk) disable iff (reset)
    (busy && !done) |=> busy)
    else record_failure("busy dropped during the run before done");

  done_after_release: assert property (@(posedge clk) disable iff (reset)
    done |-> (!result_req && !result_ack))
    else record_failure("done came before the last result handshake closed");

  busy_after_start: assert property (@(posedge clk) disable iff (reset)
    (start && !busy) |=> busy)
    else record_failure("busy did not rise the cycle after start");

  task automatic run_layers(input int run, input logic poke_start);
    int waited;
    current_run    = run;
    result_idx     = 0;
    done_count     = 0;
    fifo_full_seen = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (poke_start) begin
      // Second start in the middle of the run must be ignored
      while (result_idx < POKE_IDX) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    waited = 0;
    while (done !== 1'b1 && waited < RUN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (done !== 1'b1) begin
      record_failure($sformatf("done did not arrive within %0d cycles", RUN_TIMEOUT));
    end
    repeat (3) @(posedge clk);
    check_field("results per run", RUN_RESULTS, result_idx);
    check_field("done pulses per run", 1, done_count);
    check_field("busy after done", 0, busy);
    check_true(fifo_full_seen, "job FIFO never filled during the long result hold");
  endtask

  initial begin : main_sequence
    reset        = 1'b1;
    start        = 1'b0;
    check_count  = 0;
    fail_count   = 0;
    test_count   = 0;
    tests_failed = 0;
    done_count   = 0;
    result_idx   = 0;
    current_run  = 0;
    build_expected_results();

    begin_test("reset_idle");
    repeat (RESET_CYCLES) @(posedge clk);
    check_field("busy in reset", 0, busy);
    check_field("result_req in reset", 0, result_req);
    reset <= 1'b0;
    repeat (10) begin
      @(posedge clk);
      check_field("busy before start", 0, busy);
      check_field("done before start", 0, done);
      check_field("result_req before start", 0, result_req);
    end
    end_test();

    begin_test("run_1_with_start_while_busy");
    run_layers(1, 1'b1);
    end_test();

    begin_test("idle_after_run_1");
    repeat (20) begin
      @(posedge clk);
      check_field("busy after run", 0, busy);
      check_field("done after run", 0, done);
      check_field("result_req after run", 0, result_req);
    end
    end_test();

    begin_test("run_2_repeat");
    run_layers(2, 1'b0);
    end_test();

    $display("Tests run %0d, failed %0d, checks %0d, failures %0d",
             test_count, tests_failed, check_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
